/* rtl/rob_pkg.sv */
//####################################################################
// shared types and default sizes for the two-thread reorder buffer
// compile ahead of every rtl and testbench file
//####################################################################
package rob_pkg;

	typedef logic [63:0] pc_t;	// instruction address
	typedef logic [4:0] arn_t;	// architectural register number
	typedef logic thread_t;	// 1 selects thread 1, 0 selects thread 2

	parameter thread_t thread_1 = 1'b1;
	parameter thread_t thread_2 = 1'b0;

	// must stay a power of two, pointers wrap on the extra bit
	parameter int default_rob_depth = 16;
	parameter int default_prf_size = 64;
	parameter int default_fu_count = 6;	// completion ports

endpackage

/* rtl/rob_dispatch.sv */
`timescale 1ns/1ps
//####################################################################
// dispatch side of the reorder buffer: tail pointers per thread,
// free space check against the commit heads, allocation enables
// and the entry indices handed back to the reservation stations
//####################################################################
module rob_dispatch #(
	parameter int rob_depth = rob_pkg::default_rob_depth
) (
	input logic clock,
	input logic reset,
	input logic inst1_valid,
	input logic inst2_valid,	// only meaningful with inst1_valid
	input rob_pkg::thread_t dispatch_thread,
	input logic [$clog2(rob_depth):0] head_ptr_t1,
	input logic [$clog2(rob_depth):0] head_ptr_t2,
	input logic squash_t1,
	input logic squash_t2,
	output logic ready_t1,
	output logic ready_t2,
	output logic [$clog2(rob_depth)-1:0] inst1_rob_idx,
	output logic [$clog2(rob_depth)-1:0] inst2_rob_idx,
	output logic alloc1_en_t1,
	output logic alloc2_en_t1,
	output logic alloc1_en_t2,
	output logic alloc2_en_t2,
	output logic [$clog2(rob_depth)-1:0] tail_idx_t1,
	output logic [$clog2(rob_depth)-1:0] tail_idx_t2
);
	import rob_pkg::*;

	localparam int idx_w = $clog2(rob_depth);
	localparam int ptr_w = idx_w + 1;

	logic [ptr_w-1:0] tail_t1;
	logic [ptr_w-1:0] tail_t2;
	logic [ptr_w-1:0] used_t1;
	logic [ptr_w-1:0] used_t2;
	logic take1;
	logic take2;

	// occupancy, the head already counts this cycle's retires
	assign used_t1 = tail_t1 - head_ptr_t1;
	assign used_t2 = tail_t2 - head_ptr_t2;

	// two free slots needed, and a squashing thread takes nothing
	assign ready_t1 = !squash_t1 && (used_t1 <= ptr_w'(rob_depth - 2));
	assign ready_t2 = !squash_t2 && (used_t2 <= ptr_w'(rob_depth - 2));

	assign take1 = inst1_valid && ((dispatch_thread == thread_1) ? ready_t1 : ready_t2);
	assign take2 = take1 && inst2_valid;

	assign alloc1_en_t1 = take1 && (dispatch_thread == thread_1);
	assign alloc2_en_t1 = take2 && (dispatch_thread == thread_1);
	assign alloc1_en_t2 = take1 && (dispatch_thread == thread_2);
	assign alloc2_en_t2 = take2 && (dispatch_thread == thread_2);

	assign tail_idx_t1 = tail_t1[idx_w-1:0];
	assign tail_idx_t2 = tail_t2[idx_w-1:0];

	// indices go back in the same cycle
	assign inst1_rob_idx = (dispatch_thread == thread_1) ? tail_idx_t1 : tail_idx_t2;
	assign inst2_rob_idx = inst1_rob_idx + 1'b1;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail_t1 <= '0;
			tail_t2 <= '0;
		end
		else
		begin
			if (squash_t1)
				tail_t1 <= head_ptr_t1;	// empties the thread behind the branch
			else
				tail_t1 <= tail_t1 + ptr_w'(alloc1_en_t1) + ptr_w'(alloc2_en_t1);
			if (squash_t2)
				tail_t2 <= head_ptr_t2;
			else
				tail_t2 <= tail_t2 + ptr_w'(alloc1_en_t2) + ptr_w'(alloc2_en_t2);
		end
	end

	// the second slot is never offered on its own
	a_inst2_alone: assert property (@(posedge clock) disable iff (reset)
		$rose(inst2_valid) |-> inst1_valid);

endmodule

/* rtl/rob_entry_array.sv */
`timescale 1ns/1ps
//####################################################################
// entry storage for one thread of the reorder buffer
// written at the tail by dispatch, marked done by the function
// units, read at head and head+1 by commit selection
//####################################################################
module rob_entry_array #(
	parameter int rob_depth = rob_pkg::default_rob_depth,
	parameter int prf_size = rob_pkg::default_prf_size,
	parameter int fu_count = rob_pkg::default_fu_count,
	parameter rob_pkg::thread_t my_thread = 1'b1
) (
	input logic clock,
	input logic reset,
	input logic alloc1_en,
	input logic alloc2_en,
	input logic [$clog2(rob_depth)-1:0] tail_idx,
	input rob_pkg::pc_t inst1_pc,
	input rob_pkg::arn_t inst1_arn_dest,
	input logic [$clog2(prf_size)-1:0] inst1_prn_dest,
	input logic inst1_is_branch,
	input rob_pkg::pc_t inst2_pc,
	input rob_pkg::arn_t inst2_arn_dest,
	input logic [$clog2(prf_size)-1:0] inst2_prn_dest,
	input logic inst2_is_branch,
	input logic [fu_count-1:0] fu_valid,
	input logic [fu_count-1:0][$clog2(rob_depth)-1:0] fu_rob_idx,
	input logic [fu_count-1:0] fu_thread,
	input logic [fu_count-1:0] fu_mispredict,
	input logic [$clog2(rob_depth)-1:0] head_idx,
	input logic retire1,	// head entry leaves
	input logic retire2,	// head+1 entry leaves
	input logic squash,
	output rob_pkg::pc_t head0_pc,
	output rob_pkg::arn_t head0_arn,
	output logic [$clog2(prf_size)-1:0] head0_prn,
	output logic head0_is_branch,
	output logic head0_mispredict,
	output logic head0_done,
	output rob_pkg::pc_t head1_pc,
	output rob_pkg::arn_t head1_arn,
	output logic [$clog2(prf_size)-1:0] head1_prn,
	output logic head1_is_branch,
	output logic head1_mispredict,
	output logic head1_done
);
	import rob_pkg::*;

	localparam int idx_w = $clog2(rob_depth);
	localparam int tag_w = $clog2(prf_size);

	pc_t pc_q [rob_depth];
	arn_t arn_q [rob_depth];
	logic [tag_w-1:0] prn_q [rob_depth];
	logic [rob_depth-1:0] branch_q;
	logic [rob_depth-1:0] misp_q;
	logic [rob_depth-1:0] valid_q;
	logic [rob_depth-1:0] done_q;
	logic [rob_depth-1:0] comp_hit;
	logic [rob_depth-1:0] comp_misp;
	logic [idx_w-1:0] tail_next;
	logic [idx_w-1:0] head_next;

	assign tail_next = tail_idx + 1'b1;
	assign head_next = head_idx + 1'b1;

	// completions for this thread, decoded to entries
	always_comb
	begin
		comp_hit = '0;
		comp_misp = '0;
		for (int i = 0; i < fu_count; i++)
		begin
			if (fu_valid[i] && (fu_thread[i] == my_thread))
			begin
				comp_hit[fu_rob_idx[i]] = 1'b1;
				comp_misp[fu_rob_idx[i]] = fu_mispredict[i];	// from the reporting port
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_q <= '0;
			done_q <= '0;
		end
		else
		begin
			done_q <= done_q | comp_hit;
			if (retire1)
			begin
				valid_q[head_idx] <= 1'b0;
				done_q[head_idx] <= 1'b0;
			end
			if (retire2)
			begin
				valid_q[head_next] <= 1'b0;
				done_q[head_next] <= 1'b0;
			end
			if (squash)
			begin
				valid_q <= '0;	// everything left is younger than the branch
				done_q <= '0;
			end
			if (alloc1_en)
			begin
				valid_q[tail_idx] <= 1'b1;
				done_q[tail_idx] <= 1'b0;
			end
			if (alloc2_en)
			begin
				valid_q[tail_next] <= 1'b1;
				done_q[tail_next] <= 1'b0;
			end
		end
	end

	// payload
	always_ff @(posedge clock)
	begin
		for (int j = 0; j < rob_depth; j++)
		begin
			if (comp_hit[j])
				misp_q[j] <= comp_misp[j];
		end
		if (alloc1_en)
		begin
			pc_q[tail_idx] <= inst1_pc;
			arn_q[tail_idx] <= inst1_arn_dest;
			prn_q[tail_idx] <= inst1_prn_dest;
			branch_q[tail_idx] <= inst1_is_branch;
			misp_q[tail_idx] <= 1'b0;
		end
		if (alloc2_en)
		begin
			pc_q[tail_next] <= inst2_pc;
			arn_q[tail_next] <= inst2_arn_dest;
			prn_q[tail_next] <= inst2_prn_dest;
			branch_q[tail_next] <= inst2_is_branch;
			misp_q[tail_next] <= 1'b0;
		end
	end

	assign head0_pc = pc_q[head_idx];
	assign head0_arn = arn_q[head_idx];
	assign head0_prn = prn_q[head_idx];
	assign head0_is_branch = branch_q[head_idx];
	assign head0_mispredict = misp_q[head_idx];
	assign head0_done = valid_q[head_idx] && done_q[head_idx];
	assign head1_pc = pc_q[head_next];
	assign head1_arn = arn_q[head_next];
	assign head1_prn = prn_q[head_next];
	assign head1_is_branch = branch_q[head_next];
	assign head1_mispredict = misp_q[head_next];
	assign head1_done = valid_q[head_next] && done_q[head_next];

	// function units only report entries that dispatch placed here
	a_comp_live: assert property (@(posedge clock) disable iff (reset)
		(comp_hit & ~valid_q) == '0);

endmodule

/* rtl/rob_commit_select.sv */
`timescale 1ns/1ps
//####################################################################
// commit side of the reorder buffer: head pointers, choice of up
// to two retiring entries per cycle with thread 1 first, and the
// squash raised by a retiring mispredicted branch
//####################################################################
module rob_commit_select #(
	parameter int rob_depth = rob_pkg::default_rob_depth,
	parameter int prf_size = rob_pkg::default_prf_size
) (
	input logic clock,
	input logic reset,
	input rob_pkg::pc_t head0_pc_t1, head1_pc_t1, head0_pc_t2, head1_pc_t2,
	input rob_pkg::arn_t head0_arn_t1, head1_arn_t1, head0_arn_t2, head1_arn_t2,
	input logic [$clog2(prf_size)-1:0] head0_prn_t1, head1_prn_t1,
	input logic [$clog2(prf_size)-1:0] head0_prn_t2, head1_prn_t2,
	input logic head0_is_branch_t1, head1_is_branch_t1,
	input logic head0_is_branch_t2, head1_is_branch_t2,
	input logic head0_mispredict_t1, head1_mispredict_t1,
	input logic head0_mispredict_t2, head1_mispredict_t2,
	input logic head0_done_t1, head1_done_t1, head0_done_t2, head1_done_t2,
	output logic [$clog2(rob_depth):0] head_ptr_t1,	// head after this cycle's retires
	output logic [$clog2(rob_depth):0] head_ptr_t2,
	output logic [$clog2(rob_depth)-1:0] head_idx_t1,
	output logic [$clog2(rob_depth)-1:0] head_idx_t2,
	output logic retire1_t1, retire2_t1, retire1_t2, retire2_t2,
	output logic squash_t1,
	output logic squash_t2,
	output logic commit1_valid,
	output rob_pkg::thread_t commit1_thread,
	output rob_pkg::pc_t commit1_pc,
	output rob_pkg::arn_t commit1_arn_dest,
	output logic [$clog2(prf_size)-1:0] commit1_prn_dest,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic commit2_valid,
	output rob_pkg::thread_t commit2_thread,
	output rob_pkg::pc_t commit2_pc,
	output rob_pkg::arn_t commit2_arn_dest,
	output logic [$clog2(prf_size)-1:0] commit2_prn_dest,
	output logic commit2_is_branch,
	output logic commit2_mispredict
);
	import rob_pkg::*;

	localparam int idx_w = $clog2(rob_depth);
	localparam int ptr_w = idx_w + 1;

	logic [ptr_w-1:0] head_t1;
	logic [ptr_w-1:0] head_t2;
	logic mp0_t1, mp1_t1, mp0_t2, mp1_t2;
	logic take0_t1;	// slot 1, thread 1 head
	logic take1_t1;	// slot 2, thread 1 head+1
	logic take0_t2_s1;
	logic take0_t2_s2;
	logic take1_t2;

	assign mp0_t1 = head0_is_branch_t1 && head0_mispredict_t1;
	assign mp1_t1 = head1_is_branch_t1 && head1_mispredict_t1;
	assign mp0_t2 = head0_is_branch_t2 && head0_mispredict_t2;
	assign mp1_t2 = head1_is_branch_t2 && head1_mispredict_t2;

	// a mispredict in slot 1 keeps its own thread out of slot 2
	assign take0_t1 = head0_done_t1;
	assign take0_t2_s1 = !head0_done_t1 && head0_done_t2;
	assign take1_t1 = take0_t1 && !mp0_t1 && head1_done_t1;
	assign take0_t2_s2 = take0_t1 && !take1_t1 && head0_done_t2;
	assign take1_t2 = take0_t2_s1 && !mp0_t2 && head1_done_t2;

	assign retire1_t1 = take0_t1;
	assign retire2_t1 = take1_t1;
	assign retire1_t2 = take0_t2_s1 || take0_t2_s2;
	assign retire2_t2 = take1_t2;

	assign squash_t1 = (take0_t1 && mp0_t1) || (take1_t1 && mp1_t1);
	assign squash_t2 = (retire1_t2 && mp0_t2) || (take1_t2 && mp1_t2);

	assign head_ptr_t1 = head_t1 + ptr_w'(retire1_t1) + ptr_w'(retire2_t1);
	assign head_ptr_t2 = head_t2 + ptr_w'(retire1_t2) + ptr_w'(retire2_t2);
	assign head_idx_t1 = head_t1[idx_w-1:0];
	assign head_idx_t2 = head_t2[idx_w-1:0];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head_t1 <= '0;
			head_t2 <= '0;
		end
		else
		begin
			head_t1 <= head_ptr_t1;
			head_t2 <= head_ptr_t2;
		end
	end

	assign commit1_valid = take0_t1 || take0_t2_s1;
	assign commit1_thread = take0_t1 ? thread_1 : thread_2;
	assign commit1_pc = take0_t1 ? head0_pc_t1 : head0_pc_t2;
	assign commit1_arn_dest = take0_t1 ? head0_arn_t1 : head0_arn_t2;
	assign commit1_prn_dest = take0_t1 ? head0_prn_t1 : head0_prn_t2;
	assign commit1_is_branch = take0_t1 ? head0_is_branch_t1 : head0_is_branch_t2;
	assign commit1_mispredict = take0_t1 ? head0_mispredict_t1 : head0_mispredict_t2;

	assign commit2_valid = take1_t1 || take0_t2_s2 || take1_t2;
	assign commit2_thread = take1_t1 ? thread_1 : thread_2;

	always_comb
	begin
		if (take1_t1)
		begin
			commit2_pc = head1_pc_t1;
			commit2_arn_dest = head1_arn_t1;
			commit2_prn_dest = head1_prn_t1;
			commit2_is_branch = head1_is_branch_t1;
			commit2_mispredict = head1_mispredict_t1;
		end
		else if (take0_t2_s2)
		begin
			commit2_pc = head0_pc_t2;	// thread 2 head behind a thread 1 slot 1
			commit2_arn_dest = head0_arn_t2;
			commit2_prn_dest = head0_prn_t2;
			commit2_is_branch = head0_is_branch_t2;
			commit2_mispredict = head0_mispredict_t2;
		end
		else
		begin
			commit2_pc = head1_pc_t2;
			commit2_arn_dest = head1_arn_t2;
			commit2_prn_dest = head1_prn_t2;
			commit2_is_branch = head1_is_branch_t2;
			commit2_mispredict = head1_mispredict_t2;
		end
	end

endmodule

/* rtl/rob_top.sv */
`timescale 1ns/1ps
//####################################################################
// two-thread reorder buffer for a two-way dispatch core
// dispatch feeds one entry array per thread, commit selection
// retires up to two finished entries per cycle
//####################################################################
module rob_top #(
	parameter int rob_depth = rob_pkg::default_rob_depth,
	parameter int prf_size = rob_pkg::default_prf_size,
	parameter int fu_count = rob_pkg::default_fu_count
) (
	input logic clock,
	input logic reset,
	input logic inst1_valid,
	input logic inst2_valid,
	input rob_pkg::thread_t dispatch_thread,
	input rob_pkg::pc_t inst1_pc,
	input rob_pkg::arn_t inst1_arn_dest,
	input logic [$clog2(prf_size)-1:0] inst1_prn_dest,
	input logic inst1_is_branch,
	input rob_pkg::pc_t inst2_pc,
	input rob_pkg::arn_t inst2_arn_dest,
	input logic [$clog2(prf_size)-1:0] inst2_prn_dest,
	input logic inst2_is_branch,
	output logic ready_t1,
	output logic ready_t2,
	output logic [$clog2(rob_depth)-1:0] inst1_rob_idx,
	output logic [$clog2(rob_depth)-1:0] inst2_rob_idx,
	input logic [fu_count-1:0] fu_valid,
	input logic [fu_count-1:0][$clog2(rob_depth)-1:0] fu_rob_idx,
	input logic [fu_count-1:0] fu_thread,
	input logic [fu_count-1:0] fu_mispredict,
	output logic commit1_valid,
	output rob_pkg::thread_t commit1_thread,
	output rob_pkg::pc_t commit1_pc,
	output rob_pkg::arn_t commit1_arn_dest,
	output logic [$clog2(prf_size)-1:0] commit1_prn_dest,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic commit2_valid,
	output rob_pkg::thread_t commit2_thread,
	output rob_pkg::pc_t commit2_pc,
	output rob_pkg::arn_t commit2_arn_dest,
	output logic [$clog2(prf_size)-1:0] commit2_prn_dest,
	output logic commit2_is_branch,
	output logic commit2_mispredict
);
	import rob_pkg::*;

	localparam int idx_w = $clog2(rob_depth);
	localparam int tag_w = $clog2(prf_size);

	pc_t head0_pc_t1, head1_pc_t1, head0_pc_t2, head1_pc_t2;
	arn_t head0_arn_t1, head1_arn_t1, head0_arn_t2, head1_arn_t2;
	logic [tag_w-1:0] head0_prn_t1, head1_prn_t1, head0_prn_t2, head1_prn_t2;
	logic head0_is_branch_t1, head1_is_branch_t1, head0_is_branch_t2, head1_is_branch_t2;
	logic head0_mispredict_t1, head1_mispredict_t1;
	logic head0_mispredict_t2, head1_mispredict_t2;
	logic head0_done_t1, head1_done_t1, head0_done_t2, head1_done_t2;
	logic [idx_w:0] head_ptr_t1, head_ptr_t2;
	logic [idx_w-1:0] head_idx_t1, head_idx_t2, tail_idx_t1, tail_idx_t2;
	logic alloc1_en_t1, alloc2_en_t1, alloc1_en_t2, alloc2_en_t2;
	logic retire1_t1, retire2_t1, retire1_t2, retire2_t2;
	logic squash_t1, squash_t2;

	// port names match the wires above
	rob_dispatch #(.rob_depth(rob_depth)) u_dispatch (.*);

	rob_entry_array #(
		.rob_depth(rob_depth),
		.prf_size(prf_size),
		.fu_count(fu_count),
		.my_thread(thread_1)
	) u_array_t1 (
		.clock, .reset,
		.alloc1_en(alloc1_en_t1), .alloc2_en(alloc2_en_t1), .tail_idx(tail_idx_t1),
		.inst1_pc, .inst1_arn_dest, .inst1_prn_dest, .inst1_is_branch,
		.inst2_pc, .inst2_arn_dest, .inst2_prn_dest, .inst2_is_branch,
		.fu_valid, .fu_rob_idx, .fu_thread, .fu_mispredict,
		.head_idx(head_idx_t1), .retire1(retire1_t1), .retire2(retire2_t1),
		.squash(squash_t1),
		.head0_pc(head0_pc_t1), .head0_arn(head0_arn_t1), .head0_prn(head0_prn_t1),
		.head0_is_branch(head0_is_branch_t1), .head0_mispredict(head0_mispredict_t1),
		.head0_done(head0_done_t1),
		.head1_pc(head1_pc_t1), .head1_arn(head1_arn_t1), .head1_prn(head1_prn_t1),
		.head1_is_branch(head1_is_branch_t1), .head1_mispredict(head1_mispredict_t1),
		.head1_done(head1_done_t1)
	);

	rob_entry_array #(
		.rob_depth(rob_depth),
		.prf_size(prf_size),
		.fu_count(fu_count),
		.my_thread(thread_2)
	) u_array_t2 (
		.clock, .reset,
		.alloc1_en(alloc1_en_t2), .alloc2_en(alloc2_en_t2), .tail_idx(tail_idx_t2),
		.inst1_pc, .inst1_arn_dest, .inst1_prn_dest, .inst1_is_branch,
		.inst2_pc, .inst2_arn_dest, .inst2_prn_dest, .inst2_is_branch,
		.fu_valid, .fu_rob_idx, .fu_thread, .fu_mispredict,
		.head_idx(head_idx_t2), .retire1(retire1_t2), .retire2(retire2_t2),
		.squash(squash_t2),
		.head0_pc(head0_pc_t2), .head0_arn(head0_arn_t2), .head0_prn(head0_prn_t2),
		.head0_is_branch(head0_is_branch_t2), .head0_mispredict(head0_mispredict_t2),
		.head0_done(head0_done_t2),
		.head1_pc(head1_pc_t2), .head1_arn(head1_arn_t2), .head1_prn(head1_prn_t2),
		.head1_is_branch(head1_is_branch_t2), .head1_mispredict(head1_mispredict_t2),
		.head1_done(head1_done_t2)
	);

	rob_commit_select #(
		.rob_depth(rob_depth),
		.prf_size(prf_size)
	) u_commit_select (.*);

endmodule

/* dv/rob_clock_gen.sv */
`timescale 1ns/1ps
//####################################################################
// clock and reset source for the reorder buffer testbench
// 20 ns period, reset held over the first three rising edges
//####################################################################
module rob_clock_gen #(
	parameter int half_period = 10,
	parameter int reset_cycles = 3
) (
	output logic clock,
	output logic reset
);
	initial
	begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		#1 reset = 1'b0;	// same offset as the stimulus
	end

endmodule

/* dv/rob_tb.sv */
`timescale 1ns/1ps
//####################################################################
// testbench for the two-thread reorder buffer
// drives dispatch and completion traffic, keeps an in-order queue
// per thread and checks every commit, index and ready against it
//####################################################################
module rob_tb;
	import rob_pkg::*;

	localparam int depth = default_rob_depth;
	localparam int idx_w = $clog2(depth);
	localparam int tag_w = $clog2(default_prf_size);
	localparam int fus = default_fu_count;
	localparam int random_pairs = 60;
	localparam int random_cycles = 300;
	localparam int drain_limit = 200;
	// eight bounded drains and the random phase plus a margin for short steps
	localparam int watchdog_cycles = random_cycles + 8 * drain_limit + 600;

	logic clock, reset;
	logic inst1_valid, inst2_valid;
	thread_t dispatch_thread;
	pc_t inst1_pc, inst2_pc;
	arn_t inst1_arn_dest, inst2_arn_dest;
	logic [tag_w-1:0] inst1_prn_dest, inst2_prn_dest;
	logic inst1_is_branch, inst2_is_branch;
	logic ready_t1, ready_t2;
	logic [idx_w-1:0] inst1_rob_idx, inst2_rob_idx;
	logic [fus-1:0] fu_valid, fu_thread, fu_mispredict;
	logic [fus-1:0][idx_w-1:0] fu_rob_idx;
	logic commit1_valid, commit2_valid;
	thread_t commit1_thread, commit2_thread;
	pc_t commit1_pc, commit2_pc;
	arn_t commit1_arn_dest, commit2_arn_dest;
	logic [tag_w-1:0] commit1_prn_dest, commit2_prn_dest;
	logic commit1_is_branch, commit2_is_branch;
	logic commit1_mispredict, commit2_mispredict;

	// reference model, indexed by thread value then entry index
	pc_t exp_pc [2][depth];
	arn_t exp_arn [2][depth];
	logic [tag_w-1:0] exp_prn [2][depth];
	logic exp_branch [2][depth];
	logic exp_done [2][depth];
	logic exp_misp [2][depth];
	int m_head [2];
	int m_count [2];
	logic exp_squash [2];

	int seed = 54;
	int checks = 0;
	int errors = 0;
	int test_start, sent, cycle_count;
	logic taken;

	rob_clock_gen u_clock_gen (.clock, .reset);

	rob_top #(
		.rob_depth(depth),
		.prf_size(default_prf_size),
		.fu_count(fus)
	) u_rob_top (.*);

	task automatic expect_true(input logic ok, input string what);
		checks++;
		assert (ok === 1'b1)
		else
		begin
			errors++;
			$display("Error at %0t ns: %s", $time, what);
		end
	endtask

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	function automatic logic head_done(input thread_t t, input int k);
		return (m_count[t] > k) && exp_done[t][(m_head[t] + k) % depth];
	endfunction

	function automatic logic head_misp(input thread_t t);
		return exp_branch[t][m_head[t]] && exp_misp[t][m_head[t]];
	endfunction

	function automatic logic ready_of(input thread_t t);
		return (t == thread_1) ? ready_t1 : ready_t2;
	endfunction

	task automatic clear_model();
		m_head[0] = 0;
		m_head[1] = 0;
		m_count[0] = 0;
		m_count[1] = 0;
	endtask

	task automatic push_entry(input thread_t t, input int i, input pc_t pc, input arn_t arn,
		input logic [tag_w-1:0] prn, input logic br);
		exp_pc[t][i] = pc;
		exp_arn[t][i] = arn;
		exp_prn[t][i] = prn;
		exp_branch[t][i] = br;
		exp_done[t][i] = 1'b0;
		exp_misp[t][i] = 1'b0;
		m_count[t]++;
	endtask

	// pops the front of the thread queue and compares it with a commit slot
	task automatic retire_slot(input int slot, input thread_t t, input pc_t pc, input arn_t arn,
		input logic [tag_w-1:0] prn, input logic br, input logic misp);
		int i;
		i = m_head[t];
		expect_true(pc === exp_pc[t][i] && prn === exp_prn[t][i] && arn === exp_arn[t][i],
			$sformatf("slot %0d thread %0d entry %0d gave pc %h prn %0d, expected pc %h prn %0d",
			slot, t ? 1 : 2, i, pc, prn, exp_pc[t][i], exp_prn[t][i]));
		expect_true(br === exp_branch[t][i] && misp === exp_misp[t][i],
			$sformatf("slot %0d thread %0d entry %0d branch/mispredict %b%b, expected %b%b",
			slot, t ? 1 : 2, i, br, misp, exp_branch[t][i], exp_misp[t][i]));
		exp_done[t][i] = 1'b0;
		m_head[t] = (i + 1) % depth;
		if (exp_branch[t][i] && exp_misp[t][i])
		begin
			exp_squash[t] = 1'b1;
			m_count[t] = 0;	// younger entries of the thread are gone
		end
		else
			m_count[t]--;
	endtask

	task automatic check_commits();
		logic h1, h2, e1_valid, e2_valid;
		thread_t e1_thread, e2_thread;
		h1 = head_done(thread_1, 0);
		h2 = head_done(thread_2, 0);
		e1_valid = h1 || h2;
		e1_thread = h1 ? thread_1 : thread_2;
		e2_valid = 1'b0;
		e2_thread = thread_2;
		if (h1 && !head_misp(thread_1) && head_done(thread_1, 1))
		begin
			e2_valid = 1'b1;
			e2_thread = thread_1;
		end
		else if (h1)
			e2_valid = h2;	// thread 2 head behind thread 1
		else if (h2)
			e2_valid = !head_misp(thread_2) && head_done(thread_2, 1);
		exp_squash[0] = 1'b0;
		exp_squash[1] = 1'b0;
		expect_true(commit1_valid === e1_valid,
			$sformatf("commit1_valid is %b, expected %b", commit1_valid, e1_valid));
		expect_true(commit2_valid === e2_valid,
			$sformatf("commit2_valid is %b, expected %b", commit2_valid, e2_valid));
		if (e1_valid && commit1_valid)
		begin
			expect_true(commit1_thread === e1_thread, "commit slot 1 on the wrong thread");
			retire_slot(1, e1_thread, commit1_pc, commit1_arn_dest, commit1_prn_dest,
				commit1_is_branch, commit1_mispredict);
		end
		if (e2_valid && commit2_valid)
		begin
			expect_true(commit2_thread === e2_thread, "commit slot 2 on the wrong thread");
			retire_slot(2, e2_thread, commit2_pc, commit2_arn_dest, commit2_prn_dest,
				commit2_is_branch, commit2_mispredict);
		end
		expect_true(u_rob_top.squash_t1 === exp_squash[thread_1], "squash_t1 has the wrong value");
		expect_true(u_rob_top.squash_t2 === exp_squash[thread_2], "squash_t2 has the wrong value");
		expect_true(ready_t1 === (!exp_squash[thread_1] && m_count[thread_1] <= depth - 2),
			$sformatf("ready_t1 is %b with %0d entries", ready_t1, m_count[thread_1]));
		expect_true(ready_t2 === (!exp_squash[thread_2] && m_count[thread_2] <= depth - 2),
			$sformatf("ready_t2 is %b with %0d entries", ready_t2, m_count[thread_2]));
	endtask

	task automatic record_completions();
		for (int p = 0; p < fus; p++)
		begin
			if (fu_valid[p])
			begin
				exp_done[fu_thread[p]][fu_rob_idx[p]] = 1'b1;
				exp_misp[fu_thread[p]][fu_rob_idx[p]] = fu_mispredict[p];
			end
		end
	endtask

	task automatic record_dispatch();
		thread_t t;
		int tail;
		t = dispatch_thread;
		tail = (m_head[t] + m_count[t]) % depth;
		// the tail of a squashing thread only moves at the next edge
		if (inst1_valid && !exp_squash[t])
			expect_true(inst1_rob_idx === idx_w'(tail) && inst2_rob_idx === idx_w'(tail + 1),
				$sformatf("thread %0d dispatch returned index %0d, expected %0d",
				t ? 1 : 2, inst1_rob_idx, tail));
		if (inst1_valid && !exp_squash[t] && m_count[t] <= depth - 2)
		begin
			push_entry(t, tail, inst1_pc, inst1_arn_dest, inst1_prn_dest, inst1_is_branch);
			if (inst2_valid)
				push_entry(t, (tail + 1) % depth, inst2_pc, inst2_arn_dest, inst2_prn_dest,
					inst2_is_branch);
		end
	endtask

	// outputs settle well before the falling edge
	initial
	begin
		@(posedge clock);	// registers hold their reset values from here on
		forever
		begin
			@(negedge clock);
			if (reset)
				clear_model();
			check_commits();	// what was recorded so far shows at the commit ports
			if (!reset)
			begin
				record_completions();
				record_dispatch();
			end
		end
	end

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic set_idle();
		inst1_valid = 1'b0;
		inst2_valid = 1'b0;
		dispatch_thread = thread_1;
		inst1_pc = '0;
		inst2_pc = '0;
		inst1_arn_dest = '0;
		inst2_arn_dest = '0;
		inst1_prn_dest = '0;
		inst2_prn_dest = '0;
		inst1_is_branch = 1'b0;
		inst2_is_branch = 1'b0;
		fu_valid = '0;
		fu_thread = '0;
		fu_mispredict = '0;
		fu_rob_idx = '0;
	endtask

	task automatic offer_pair(input thread_t t, input logic two, input logic br1, input logic br2);
		dispatch_thread = t;
		inst1_valid = 1'b1;
		inst2_valid = two;
		inst1_pc = {$random(seed), $random(seed)};
		inst2_pc = {$random(seed), $random(seed)};
		inst1_arn_dest = arn_t'($random(seed));
		inst2_arn_dest = arn_t'($random(seed));
		inst1_prn_dest = tag_w'($random(seed));
		inst2_prn_dest = tag_w'($random(seed));
		inst1_is_branch = br1;
		inst2_is_branch = br2;
	endtask

	// holds the offered pair until the thread's ready takes it
	task automatic wait_taken();
		int waited;
		taken = 1'b0;
		waited = 0;
		while (!taken && waited < drain_limit)
		begin
			@(negedge clock);
			taken = ready_of(dispatch_thread);
			next_cycle();
			fu_valid = '0;
			waited++;
		end
		inst1_valid = 1'b0;
		inst2_valid = 1'b0;
		checks++;
		if (!taken)
		begin
			errors++;
			$display("dispatch to thread %0d was never accepted", dispatch_thread ? 1 : 2);
		end
	endtask

	task automatic dispatch_pair(input thread_t t, input logic two, input logic br1,
		input logic br2);
		offer_pair(t, two, br1, br2);
		wait_taken();
	endtask

	task automatic set_port(input int p, input thread_t t, input int i, input logic misp);
		fu_valid[p] = 1'b1;
		fu_thread[p] = t;
		fu_rob_idx[p] = idx_w'(i);
		fu_mispredict[p] = misp;
	endtask

	// pos counts from the oldest entry of the thread
	task automatic complete_pos(input int p, input thread_t t, input int pos, input logic misp);
		set_port(p, t, (m_head[t] + pos) % depth, misp);
	endtask

	task automatic pulse_completions();
		next_cycle();
		fu_valid = '0;
		fu_mispredict = '0;
	endtask

	task automatic pick_completions();
		thread_t t;
		int i;
		logic dup;
		fu_valid = '0;
		fu_mispredict = '0;
		for (int p = 0; p < fus; p++)
		begin
			t = thread_t'(rand_below(2));
			if (m_count[t] > 0 && rand_below(2) == 0)
			begin
				i = (m_head[t] + rand_below(m_count[t])) % depth;
				dup = 1'b0;
				for (int q = 0; q < p; q++)
					if (fu_valid[q] && fu_thread[q] == t && fu_rob_idx[q] == i)
						dup = 1'b1;
				if (!exp_done[t][i] && !dup)
					set_port(p, t, i, 1'b0);
			end
		end
	endtask

	// completes what is left until both threads are empty
	task automatic drain();
		int waited;
		waited = 0;
		while ((m_count[0] != 0 || m_count[1] != 0) && waited < drain_limit)
		begin
			pick_completions();
			next_cycle();
			waited++;
		end
		fu_valid = '0;
		checks++;
		if (m_count[0] != 0 || m_count[1] != 0)
		begin
			errors++;
			$display("entries were still waiting to commit after %0d cycles", drain_limit);
		end
	endtask

	task automatic report_test(input int num, input string name, input int start);
		$display("test %0d %s finished with %0d errors", num, name, errors - start);
	endtask

	initial
	begin
		set_idle();
		test_start = errors;
		@(negedge reset);
		next_cycle();
		next_cycle();
		report_test(1, "reset", test_start);

		test_start = errors;
		sent = 0;
		cycle_count = 0;
		while (sent < random_pairs && cycle_count < random_cycles)
		begin
			if (!inst1_valid && rand_below(2) == 0)
				offer_pair(thread_t'(rand_below(2)), rand_below(2) == 0, 1'(rand_below(2)), 1'b0);
			pick_completions();
			@(negedge clock);
			taken = inst1_valid && ready_of(dispatch_thread);
			next_cycle();
			if (taken)
			begin
				sent++;
				inst1_valid = 1'b0;
				inst2_valid = 1'b0;
			end
			cycle_count++;
		end
		fu_valid = '0;
		if (inst1_valid)
			wait_taken();
		drain();
		report_test(2, "in-order retire", test_start);

		test_start = errors;
		dispatch_pair(thread_1, 1'b1, 1'b0, 1'b0);
		dispatch_pair(thread_1, 1'b1, 1'b0, 1'b0);
		dispatch_pair(thread_2, 1'b1, 1'b0, 1'b0);
		dispatch_pair(thread_2, 1'b1, 1'b0, 1'b0);
		complete_pos(0, thread_1, 1, 1'b0);	// thread 1 head stays open
		complete_pos(1, thread_2, 0, 1'b0);
		complete_pos(2, thread_2, 1, 1'b0);
		pulse_completions();
		complete_pos(0, thread_1, 0, 1'b0);
		complete_pos(1, thread_1, 2, 1'b0);
		complete_pos(2, thread_1, 3, 1'b0);
		complete_pos(3, thread_2, 2, 1'b0);
		complete_pos(4, thread_2, 3, 1'b0);
		pulse_completions();
		drain();
		dispatch_pair(thread_1, 1'b1, 1'b0, 1'b0);
		dispatch_pair(thread_2, 1'b1, 1'b0, 1'b0);
		complete_pos(0, thread_1, 0, 1'b0);	// slot 2 goes to the thread 2 head
		complete_pos(1, thread_2, 0, 1'b0);
		pulse_completions();
		drain();
		report_test(3, "dual commit and priority", test_start);

		test_start = errors;
		for (int k = 0; k < depth / 2; k++)
			dispatch_pair(thread_2, 1'b1, 1'b0, 1'b0);
		offer_pair(thread_2, 1'b1, 1'b0, 1'b0);
		repeat (4) next_cycle();	// held while thread 2 is full
		complete_pos(0, thread_2, 0, 1'b0);
		complete_pos(1, thread_2, 1, 1'b0);
		wait_taken();
		drain();
		report_test(4, "back-pressure", test_start);

		test_start = errors;
		dispatch_pair(thread_1, 1'b1, 1'b0, 1'b0);
		dispatch_pair(thread_1, 1'b1, 1'b1, 1'b0);
		dispatch_pair(thread_1, 1'b1, 1'b0, 1'b0);
		dispatch_pair(thread_2, 1'b1, 1'b0, 1'b0);
		for (int k = 0; k < 6; k++)
			complete_pos(k, thread_1, k, k == 2);	// branch in slot 1 position
		pulse_completions();
		complete_pos(0, thread_2, 0, 1'b0);
		complete_pos(1, thread_2, 1, 1'b0);
		pulse_completions();
		drain();
		dispatch_pair(thread_1, 1'b1, 1'b0, 1'b0);
		drain();
		dispatch_pair(thread_2, 1'b1, 1'b0, 1'b1);
		dispatch_pair(thread_2, 1'b1, 1'b0, 1'b0);
		for (int k = 0; k < 4; k++)
			complete_pos(k, thread_2, k, k == 1);	// squash raised from slot 2
		pulse_completions();
		drain();
		dispatch_pair(thread_2, 1'b1, 1'b0, 1'b0);
		drain();
		report_test(5, "squash", test_start);

		$display("checks passed %0d, failed %0d", checks - errors, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("the run was still going after %0d cycles, the DUT or a test hung",
			watchdog_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* tb.f */
rtl/rob_pkg.sv
rtl/rob_dispatch.sv
rtl/rob_entry_array.sv
rtl/rob_commit_select.sv
rtl/rob_top.sv
dv/rob_clock_gen.sv
dv/rob_tb.sv
